// File: src/radio_pkg.sv
package radio_pkg;

   // ---------------------
   // DAC sample format
   // ---------------------

   localparam int SAMPLE_W = 16;

   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // one DAC word, I in the upper half
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_t;

   localparam sample_t TAG_AMPLITUDE = 16'sd32767;   // level for a one bit

endpackage

// File: src/tag_tx_pkg.sv
package tag_tx_pkg;

   // ---------------------
   // frame layout
   // ---------------------

   localparam int FRAME_BITS = 32;

   typedef logic [FRAME_BITS-1:0] frame_bits_t;   // sent msb first

   // frame opcode
   typedef enum logic {
      TX_NOW     = 1'b0,   // send when reached
      TX_ON_TRIG = 1'b1    // hold until front-panel trigger
   } tx_cmd_e;

   typedef struct packed {
      tx_cmd_e     cmd;
      frame_bits_t bits;
   } frame_t;

   // sequencer states
   typedef enum logic [1:0] {
      ST_IDLE      = 2'd0,
      ST_WAIT_TRIG = 2'd1,
      ST_SEND      = 2'd2
   } tx_state_e;

endpackage

// File: src/tag_frame_if.sv
interface tag_frame_if;
   import tag_tx_pkg::*;

   frame_t frame;   // head entry of the buffer
   logic   avail;   // buffer not empty
   logic   take;    // consume head, one cycle

   modport fifo (
      output frame,
      output avail,
      input  take
   );

   modport fsm (
      input  avail,
      input  frame,
      output take
   );

   // bits are loaded on the take edge
   modport path (
      input  frame,
      input  take
   );

endinterface

// File: src/frame_fifo.sv
module frame_fifo #(
   parameter int FIFO_DEPTH = 2
) (
   input  logic               radio_clk,
   input  logic               i_rst_n,
   input  logic               i_wr_valid,
   input  tag_tx_pkg::frame_t i_wr_frame,
   output logic               o_credit,
   tag_frame_if.fifo          frame_fifo
);
   import tag_tx_pkg::*;

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   frame_t           mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             wr_en;
   logic             rd_en;

   // wrap at depth, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign full  = (count == CNT_W'(FIFO_DEPTH));
   assign wr_en = i_wr_valid && !full;
   assign rd_en = frame_fifo.take && frame_fifo.avail;

   assign frame_fifo.avail = (count != '0);
   assign frame_fifo.frame = mem[rd_ptr];   // show-ahead read

   always_ff @(posedge radio_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= i_wr_frame;
      end
   end

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         o_credit <= 1'b0;
      end else begin
         if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
         if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
         o_credit <= rd_en;   // one credit back per removed entry
      end
   end

endmodule

// File: src/symbol_timer.sv
module symbol_timer #(
   parameter int SAMPLES_PER_SYMBOL = 9
) (
   input  logic radio_clk,
   input  logic i_rst_n,
   input  logic i_load,
   input  logic i_run,
   output logic o_sym_end,
   output logic o_frame_end
);
   import tag_tx_pkg::*;

   localparam int SAMP_W = (SAMPLES_PER_SYMBOL > 1) ? $clog2(SAMPLES_PER_SYMBOL) : 1;
   localparam int BIT_W  = $clog2(FRAME_BITS);

   logic [SAMP_W-1:0] samp_cnt;   // sample within symbol
   logic [BIT_W-1:0]  bit_cnt;    // bit index within frame
   logic              last_samp;
   logic              last_bit;

   assign last_samp   = (samp_cnt == SAMP_W'(SAMPLES_PER_SYMBOL - 1));
   assign last_bit    = (bit_cnt == BIT_W'(FRAME_BITS - 1));
   assign o_sym_end   = i_run && last_samp;
   assign o_frame_end = o_sym_end && last_bit;

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         samp_cnt <= '0;
         bit_cnt  <= '0;
      end else if (i_load) begin
         samp_cnt <= '0;
         bit_cnt  <= '0;
      end else if (i_run) begin
         if (last_samp) begin
            samp_cnt <= '0;
            bit_cnt  <= last_bit ? '0 : bit_cnt + 1'b1;
         end else begin
            samp_cnt <= samp_cnt + 1'b1;
         end
      end
   end

endmodule

// File: src/tag_tx_fsm.sv
module tag_tx_fsm (
   input  logic     radio_clk,
   input  logic     i_rst_n,
   input  logic     i_trigger,
   input  logic     i_sym_end,
   input  logic     i_frame_end,
   output logic     o_load,
   output logic     o_run,
   output logic     o_sending,
   tag_frame_if.fsm frame
);
   import tag_tx_pkg::*;

   tx_state_e state;
   tx_state_e state_nxt;

   // --------------------
   // next state
   // --------------------
   always_comb begin
      state_nxt  = state;
      frame.take = 1'b0;
      case (state)
         ST_IDLE: begin
            if (frame.avail) begin
               frame.take = 1'b1;   // take at once, opcode picks the path
               if (frame.frame.cmd == TX_ON_TRIG) begin
                  state_nxt = ST_WAIT_TRIG;
               end else begin
                  state_nxt = ST_SEND;
               end
            end
         end
         ST_WAIT_TRIG: begin
            if (i_trigger) begin
               state_nxt = ST_SEND;
            end
         end
         ST_SEND: begin
            // frame end only counts on a symbol boundary
            if (i_sym_end && i_frame_end) begin
               state_nxt = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign o_load    = frame.take;   // restart counts with each new frame
   assign o_run     = (state == ST_SEND);
   assign o_sending = (state == ST_SEND);

endmodule

// File: src/tx_symbol_path.sv
module tx_symbol_path (
   input  logic           radio_clk,
   input  logic           i_rst_n,
   input  logic           i_sending,
   input  logic           i_sym_end,
   input  radio_pkg::iq_t i_host_tx,
   output radio_pkg::iq_t o_tx,
   output logic           o_tx_valid,
   output logic           o_tag_gate,
   tag_frame_if.path      frame
);
   import radio_pkg::*;
   import tag_tx_pkg::*;

   frame_bits_t shift_reg;
   iq_t         bpsk_iq;

   // --------------------
   // bit shifter
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (frame.take) begin
         shift_reg <= frame.frame.bits;
      end else if (i_sym_end) begin
         shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};   // next bit to msb
      end
   end

   // BPSK on I only
   always_comb begin
      bpsk_iq.q = '0;
      if (shift_reg[FRAME_BITS-1]) begin
         bpsk_iq.i = TAG_AMPLITUDE;
      end else begin
         bpsk_iq.i = -TAG_AMPLITUDE;
      end
   end

   // --------------------
   // DAC output register
   // --------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_tx       <= '0;
         o_tx_valid <= 1'b0;
         o_tag_gate <= 1'b0;
      end else begin
         o_tx       <= i_sending ? bpsk_iq : i_host_tx;   // host sample when idle
         o_tx_valid <= i_sending;
         o_tag_gate <= i_sending;   // tag enabled while on air
      end
   end

endmodule

// File: src/tag_tx_core.sv
module tag_tx_core #(
   parameter int SAMPLES_PER_SYMBOL = 9,
   parameter int FIFO_DEPTH         = 2
) (
   input  logic                    radio_clk,
   input  logic                    i_rst_n,
   input  logic                    i_frame_valid,
   input  tag_tx_pkg::tx_cmd_e     i_frame_cmd,
   input  tag_tx_pkg::frame_bits_t i_frame_bits,
   input  logic                    i_trigger,
   input  radio_pkg::iq_t          i_host_tx,
   output logic                    o_credit,
   output radio_pkg::iq_t          o_tx,
   output logic                    o_tx_valid,
   output logic                    o_tag_gate
);

   tag_frame_if frame_ch ();

   logic tmr_load;
   logic tmr_run;
   logic sym_end;
   logic frame_end;
   logic sending;

   // frame buffer, opcode packed above the bits
   frame_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) fifo_i (
      .radio_clk  (radio_clk),
      .i_rst_n    (i_rst_n),
      .i_wr_valid (i_frame_valid),
      .i_wr_frame ({i_frame_cmd, i_frame_bits}),
      .o_credit   (o_credit),
      .frame_fifo (frame_ch.fifo)
   );

   symbol_timer #(
      .SAMPLES_PER_SYMBOL (SAMPLES_PER_SYMBOL)
   ) timer_i (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_load      (tmr_load),
      .i_run       (tmr_run),
      .o_sym_end   (sym_end),
      .o_frame_end (frame_end)
   );

   tag_tx_fsm fsm_i (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_trigger   (i_trigger),
      .i_sym_end   (sym_end),
      .i_frame_end (frame_end),
      .o_load      (tmr_load),
      .o_run       (tmr_run),
      .o_sending   (sending),
      .frame       (frame_ch.fsm)
   );

   tx_symbol_path path_i (
      .radio_clk  (radio_clk),
      .i_rst_n    (i_rst_n),
      .i_sending  (sending),
      .i_sym_end  (sym_end),
      .i_host_tx  (i_host_tx),
      .o_tx       (o_tx),
      .o_tx_valid (o_tx_valid),
      .o_tag_gate (o_tag_gate),
      .frame      (frame_ch.path)
   );

endmodule

// File: test/tag_tx_assertions.sv
module tag_tx_assertions (
   input logic radio_clk,
   input logic i_rst_n,
   input logic i_tx_valid,
   input logic i_tag_gate,
   input logic i_take,
   input logic i_avail,
   input logic i_wr_valid,
   input logic i_full
);

   int unsigned fail_count = 0;   // failed assertions so far

   // --------------------
   // tag gate and buffer
   // --------------------
   gate_matches_valid: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      i_tag_gate == i_tx_valid)
      else begin
         $error("tag gate and tx valid differ");
         fail_count++;
      end

   take_needs_avail: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      i_take |-> i_avail)
      else begin
         $error("frame taken from an empty buffer");
         fail_count++;
      end

   // sender must hold a credit
   no_write_when_full: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      i_wr_valid |-> !i_full)
      else begin
         $error("frame written into a full buffer");
         fail_count++;
      end

endmodule

bind tag_tx_core tag_tx_assertions asrt_i (
   .radio_clk  (radio_clk),
   .i_rst_n    (i_rst_n),
   .i_tx_valid (o_tx_valid),
   .i_tag_gate (o_tag_gate),
   .i_take     (frame_ch.take),
   .i_avail    (frame_ch.avail),
   .i_wr_valid (i_frame_valid),
   .i_full     (fifo_i.full)
);

// File: test/tb_tag_tx.sv
module tb_tag_tx;
   import radio_pkg::*;
   import tag_tx_pkg::*;

   localparam int SAMPLES_PER_SYMBOL = 9;
   localparam int FIFO_DEPTH         = 2;   // also the starting credit count
   localparam int FRAME_LEN          = FRAME_BITS * SAMPLES_PER_SYMBOL;
   localparam int NUM_ROWS           = 6;
   localparam int MAX_TRIG_DELAY     = 20;  // table delay plus random extra
   localparam int WATCHDOG_CYCLES    = NUM_ROWS * (FRAME_LEN + MAX_TRIG_DELAY + 20);

   typedef struct {
      tx_cmd_e     cmd;
      frame_bits_t bits;
      int          trig_delay;
      bit          b2b;   // written right after the row before
   } stim_t;

   logic        radio_clk = 1'b0;
   logic        i_rst_n;
   logic        i_frame_valid;
   tx_cmd_e     i_frame_cmd;
   frame_bits_t i_frame_bits;
   logic        i_trigger;
   iq_t         i_host_tx;
   logic        o_credit;
   iq_t         o_tx;
   logic        o_tx_valid;
   logic        o_tag_gate;

   stim_t stim [NUM_ROWS];
   iq_t   exp_q [$];   // reference samples, oldest first
   int    errors;
   int    checks;
   int    tests;
   int    tests_failed;
   int    credit_pulses;
   int    frames_sent;
   int    run_len;
   bit    monitor_on;

   tag_tx_core dut_i (.*);

   always #10 radio_clk = ~radio_clk;

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge radio_clk);
      $display("timeout: the run hung and did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

   // ---------------------
   // reference and checks
   // ---------------------
   function automatic iq_t bpsk_sample(input logic one);
      iq_t s;
      s.i = one ? TAG_AMPLITUDE : -TAG_AMPLITUDE;
      s.q = '0;
      return s;
   endfunction

   task automatic expect_true(input bit ok, input string what);
      checks++;
      assert (ok) else begin
         $display("error at time %0t: %s", $time, what);
         errors++;
      end
   endtask

   task automatic check_outputs();
      iq_t exp_s;
      expect_true(o_tag_gate == o_tx_valid, "o_tag_gate differs from o_tx_valid");
      if (o_credit) credit_pulses++;
      if (o_tx_valid) begin
         run_len++;
         if (exp_q.size() == 0) begin
            expect_true(1'b0, $sformatf("unexpected valid sample %h", o_tx));
         end else begin
            exp_s = exp_q.pop_front();
            expect_true(o_tx == exp_s, $sformatf("sample %0d is %h, expected %h",
                                                 run_len - 1, o_tx, exp_s));
         end
      end else begin
         expect_true(o_tx == i_host_tx, $sformatf("idle o_tx %h, host sample was %h",
                                                  o_tx, i_host_tx));
         if (run_len != 0) begin
            expect_true(run_len == FRAME_LEN, $sformatf("frame had %0d samples", run_len));
            run_len = 0;
         end
      end
   endtask

   // one cycle, outputs checked before new inputs go out
   task automatic tick();
      @(negedge radio_clk);
      if (monitor_on) check_outputs();
      i_host_tx     = $urandom;
      i_frame_valid = 1'b0;
      i_trigger     = 1'b0;
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests++;
      if (errors != err_before) tests_failed++;
      $display("test %0d: %s, %0d error(s)", tests, name, errors - err_before);
   endtask

   task automatic run_group(input int first, input int last);
      int err_before;
      int cred_before;
      int waited;
      int delay;
      err_before  = errors;
      cred_before = credit_pulses;
      for (int r = first; r <= last; r++) begin
         tick();
         waited = 0;
         while (FIFO_DEPTH + credit_pulses - frames_sent <= 0 && waited < 2 * FRAME_LEN) begin
            tick();
            waited++;
         end
         if (FIFO_DEPTH + credit_pulses - frames_sent <= 0) begin
            $display("no credit came back for row %0d, frame not sent", r);
            errors++;
         end else begin
            i_frame_valid = 1'b1;
            i_frame_cmd   = stim[r].cmd;
            i_frame_bits  = stim[r].bits;
            frames_sent++;
            for (int b = FRAME_BITS - 1; b >= 0; b--) begin
               repeat (SAMPLES_PER_SYMBOL) exp_q.push_back(bpsk_sample(stim[r].bits[b]));
            end
         end
      end
      if (stim[first].cmd == TX_ON_TRIG) begin
         delay = stim[first].trig_delay + int'($urandom % 8);
         repeat (delay) begin
            tick();
            expect_true(!o_tx_valid, "o_tx_valid high before the trigger");
         end
         tick();
         i_trigger = 1'b1;
      end
      waited = 0;
      tick();
      while ((exp_q.size() != 0 || o_tx_valid) && waited < (last - first + 1) * (FRAME_LEN + 20)) begin
         tick();
         waited++;
      end
      if (exp_q.size() != 0 || o_tx_valid) begin
         $display("frames from row %0d did not finish, %0d samples missing", first, exp_q.size());
         errors++;
         exp_q.delete();
      end
      expect_true(credit_pulses - cred_before == last - first + 1,
                  $sformatf("%0d credit pulses for %0d frames", credit_pulses - cred_before,
                            last - first + 1));
      finish_test($sformatf("row %0d %s, %0d frame(s)", first, stim[first].cmd.name(),
                            last - first + 1), err_before);
   endtask

   initial begin
      int row;
      int last;
      void'($urandom(65));
      i_rst_n       = 1'b0;
      i_frame_valid = 1'b0;
      i_frame_cmd   = TX_NOW;
      i_frame_bits  = '0;
      i_trigger     = 1'b0;
      i_host_tx     = '0;
      stim[0] = '{TX_NOW,     32'hA5F0_3C81, 0,  1'b0};
      stim[1] = '{TX_NOW,     32'h8000_0001, 0,  1'b0};
      stim[2] = '{TX_ON_TRIG, 32'h1234_5678, 5,  1'b0};
      stim[3] = '{TX_NOW,     32'hFFFF_0000, 0,  1'b0};
      stim[4] = '{TX_NOW,     32'h0F0F_F0F0, 0,  1'b1};   // burst with row 3
      stim[5] = '{TX_ON_TRIG, 32'hDEAD_BEEF, 12, 1'b0};
      repeat (5) begin
         tick();
         expect_true(o_tx == '0 && !o_tx_valid && !o_tag_gate && !o_credit,
                     $sformatf("in reset o_tx %h valid %b gate %b credit %b",
                               o_tx, o_tx_valid, o_tag_gate, o_credit));
      end
      i_rst_n    = 1'b1;
      monitor_on = 1'b1;
      repeat (6) begin
         tick();
         expect_true(!o_tx_valid && !o_credit, "output active with no frame written");
      end
      finish_test("reset and idle outputs", 0);
      row = 0;
      while (row < NUM_ROWS) begin
         last = row;
         while (last + 1 < NUM_ROWS && stim[last + 1].b2b) begin
            last++;
         end
         run_group(row, last);
         row = last + 1;
      end
      errors += dut_i.asrt_i.fail_count;
      $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, tests_failed, checks,
               errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
src/radio_pkg.sv
src/tag_tx_pkg.sv
src/tag_frame_if.sv
src/frame_fifo.sv
src/symbol_timer.sv
src/tag_tx_fsm.sv
src/tx_symbol_path.sv
src/tag_tx_core.sv
test/tag_tx_assertions.sv
test/tb_tag_tx.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the tag transmitter testbench with Verilator

verilator --binary --timing --assert -f filelist.f --top-module tb_tag_tx -o sim_tag_tx
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

out=$(./obj_dir/sim_tag_tx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
exit 1
